//--- rtl/icache_defines.svh
// Instruction cache geometry, address split and bus widths
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// Processor word address and instruction word
`define ICACHE_ADDR_W      19
`define ICACHE_DATA_W      16

// Direct-mapped geometry, 4 KB of instructions in total
`define ICACHE_LINES       256
`define ICACHE_LINE_WORDS  8

// Word address split as tag | index | offset
// Offset covers LINE_WORDS, index covers LINES, tag takes the rest
`define ICACHE_OFFSET_W    3
`define ICACHE_INDEX_W     8
`define ICACHE_TAG_W       8

`endif

//--- rtl/icache_types_pkg.sv
// Plain vector types for instruction cache addresses, address fields and data
`include "icache_defines.svh"

package icache_types_pkg;

    // Word address as seen by the processor and by memory
    typedef logic [`ICACHE_ADDR_W-1:0] word_addr_t;

    // One instruction word
    typedef logic [`ICACHE_DATA_W-1:0] data_word_t;

    // Upper address bits kept per line
    typedef logic [`ICACHE_TAG_W-1:0] line_tag_t;

    // Selects one of the cache lines
    typedef logic [`ICACHE_INDEX_W-1:0] line_index_t;

    // Word within a line
    typedef logic [`ICACHE_OFFSET_W-1:0] word_offset_t;

    // Data store address, index above offset
    typedef logic [`ICACHE_INDEX_W+`ICACHE_OFFSET_W-1:0] store_addr_t;

endpackage

//--- rtl/icache_bus_pkg.sv
// Fetch and memory bus structs and the cache controller state encoding
package icache_bus_pkg;

    // Processor fetch request, held until ack
    typedef struct packed {
        logic                         access;
        icache_types_pkg::word_addr_t addr;
    } fetch_req_t;

    // Fetch response, data valid with the one-cycle ack
    typedef struct packed {
        logic                         ack;
        icache_types_pkg::data_word_t data;
    } fetch_rsp_t;

    // Memory request, held until the memory acks
    typedef struct packed {
        logic                         access;
        icache_types_pkg::word_addr_t addr;
    } mem_req_t;

    // Memory response, one word per ack
    typedef struct packed {
        logic                         ack;
        icache_types_pkg::data_word_t data;
    } mem_rsp_t;

    // Controller FSM states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        COMPARE,
        RESPOND,
        FILL,
        RETRY,
        BYPASS
    } ctrl_state_t;

endpackage

//--- rtl/icache_tag_store.sv
// Instruction cache tag and valid arrays with a registered tag compare
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_tag_store (
    input  logic                         clk,
    input  logic                         reset,
    input  icache_types_pkg::word_addr_t lookup_addr,
    output logic                         hit,
    input  logic                         fill_start,
    input  icache_types_pkg::word_addr_t fill_addr,
    input  logic                         line_done
);

    // One tag and one valid bit per line
    icache_types_pkg::line_tag_t    tags [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0]       valid;

    // Address fields of the lookup and of the line being filled
    icache_types_pkg::line_index_t  lookup_index;
    icache_types_pkg::line_tag_t    lookup_tag;
    icache_types_pkg::line_index_t  fill_index;
    icache_types_pkg::line_tag_t    fill_tag;

    // Line under fill, kept until line_done
    icache_types_pkg::line_index_t  fill_index_q;

    // Lookup pipeline stage
    icache_types_pkg::line_tag_t    stored_tag_q;
    icache_types_pkg::line_tag_t    req_tag_q;
    logic                           stored_valid_q;

    assign lookup_index = lookup_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign lookup_tag   = lookup_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign fill_index   = fill_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign fill_tag     = fill_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

    // Tag written once per miss, at the start of the fill
    always_ff @(posedge clk) begin
        if (fill_start) begin
            tags[fill_index] <= fill_tag;
        end
    end

    // Line goes invalid while it fills and valid after its last word
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid        <= '0;
            fill_index_q <= '0;
        end else begin
            if (fill_start) begin
                valid[fill_index] <= 1'b0;
                fill_index_q      <= fill_index;
            end
            if (line_done) begin
                valid[fill_index_q] <= 1'b1;
            end
        end
    end

    // Stored tag and request tag, read at the lookup edge
    always_ff @(posedge clk) begin
        stored_tag_q <= tags[lookup_index];
        req_tag_q    <= lookup_tag;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stored_valid_q <= 1'b0;
        end else begin
            stored_valid_q <= valid[lookup_index];
        end
    end

    // Compare on the registered values, hit one cycle after lookup
    assign hit = stored_valid_q && (stored_tag_q == req_tag_q);

endmodule

//--- rtl/icache_data_store.sv
// Instruction cache line data memory with one read port and one fill write port
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_data_store (
    input  logic                          clk,
    input  icache_types_pkg::store_addr_t rd_addr,
    output icache_types_pkg::data_word_t  rd_data,
    input  logic                          wr_en,
    input  icache_types_pkg::store_addr_t wr_addr,
    input  icache_types_pkg::data_word_t  wr_data
);

    // All lines back to back, addressed by index then offset
    icache_types_pkg::data_word_t mem [`ICACHE_LINES * `ICACHE_LINE_WORDS];

    // Fill side
    // One word per memory ack, only while a line is being filled
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Lookup side
    // Synchronous read, word valid in the cycle after the address
    // Reads every cycle, the controller holds the address steady
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- rtl/icache_fill_unit.sv
// Line fill sequencer: word addresses, store addresses and acknowledge count
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_fill_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          fill_start,
    input  icache_types_pkg::word_addr_t  fill_addr,
    input  logic                          word_ack,
    output icache_types_pkg::word_addr_t  fetch_addr,
    output icache_types_pkg::store_addr_t store_addr,
    output logic                          line_done
);

    // Line being filled
    icache_types_pkg::line_tag_t    tag_q;
    icache_types_pkg::line_index_t  index_q;

    // Current word and number of words already written
    icache_types_pkg::word_offset_t offset_q;
    icache_types_pkg::word_offset_t count_q;
    logic                           active_q;

    // Last word of the line
    assign line_done = active_q && word_ack &&
        (count_q == icache_types_pkg::word_offset_t'(`ICACHE_LINE_WORDS - 1));

    // Line base is fixed for the whole fill
    always_ff @(posedge clk) begin
        if (fill_start) begin
            tag_q   <= fill_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
            index_q <= fill_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
        end
    end

    // Starts at the requested word, offset wraps inside the line
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active_q <= 1'b0;
            offset_q <= '0;
            count_q  <= '0;
        end else if (fill_start) begin
            active_q <= 1'b1;
            offset_q <= fill_addr[`ICACHE_OFFSET_W-1:0];
            count_q  <= '0;
        end else if (active_q && word_ack) begin
            offset_q <= offset_q + 1'b1;
            count_q  <= count_q + 1'b1;
            if (line_done) begin
                active_q <= 1'b0;
            end
        end
    end

    // Memory address and data store address of the current word
    assign fetch_addr = {tag_q, index_q, offset_q};
    assign store_addr = {index_q, offset_q};

endmodule

//--- rtl/icache_ctrl.sv
// Instruction cache controller FSM with fetch ack and bypass steering
`timescale 1ns/10ps

module icache_ctrl (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          enabled,
    input  icache_bus_pkg::fetch_req_t    fetch_req,
    output icache_bus_pkg::fetch_rsp_t    fetch_rsp,
    output icache_bus_pkg::mem_req_t      mem_req,
    input  icache_bus_pkg::mem_rsp_t      mem_rsp,
    output icache_types_pkg::word_addr_t  lookup_addr,
    input  logic                          hit,
    input  icache_types_pkg::data_word_t  rd_data,
    output logic                          fill_start,
    output icache_types_pkg::word_addr_t  fill_addr,
    input  icache_types_pkg::word_addr_t  fill_fetch_addr,
    input  logic                          line_done
);

    icache_bus_pkg::ctrl_state_t  state_q;
    icache_bus_pkg::ctrl_state_t  state_d;

    // Request address, latched when a fetch is accepted
    icache_types_pkg::word_addr_t req_addr_q;

    // Registered fetch response
    icache_types_pkg::data_word_t data_q;
    logic                         ack_q;

    // New fetch seen in IDLE
    // Not while the previous ack is still out, the request is then still held
    logic                         start;

    assign start = (state_q == icache_bus_pkg::IDLE) && fetch_req.access && !ack_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_bus_pkg::IDLE: begin
                if (start) begin
                    state_d = enabled ? icache_bus_pkg::LOOKUP : icache_bus_pkg::BYPASS;
                end
            end
            icache_bus_pkg::LOOKUP:  state_d = icache_bus_pkg::COMPARE;
            icache_bus_pkg::COMPARE: begin
                state_d = hit ? icache_bus_pkg::RESPOND : icache_bus_pkg::FILL;
            end
            icache_bus_pkg::FILL: begin
                if (line_done) begin
                    state_d = icache_bus_pkg::RETRY;
                end
            end
            // Look the line up again once it is complete
            icache_bus_pkg::RETRY:   state_d = icache_bus_pkg::LOOKUP;
            icache_bus_pkg::RESPOND: state_d = icache_bus_pkg::IDLE;
            icache_bus_pkg::BYPASS: begin
                if (mem_rsp.ack) begin
                    state_d = icache_bus_pkg::IDLE;
                end
            end
            default: state_d = icache_bus_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= icache_bus_pkg::IDLE;
            ack_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            // One-cycle ack, right after RESPOND
            ack_q   <= (state_q == icache_bus_pkg::RESPOND);
        end
    end

    // Word read in LOOKUP is still on rd_data during RESPOND
    always_ff @(posedge clk) begin
        if (start) begin
            req_addr_q <= fetch_req.addr;
        end
        if (state_q == icache_bus_pkg::RESPOND) begin
            data_q <= rd_data;
        end
    end

    // Both stores and the fill see the held request address
    assign lookup_addr = req_addr_q;
    assign fill_addr   = req_addr_q;
    assign fill_start  = (state_q == icache_bus_pkg::COMPARE) && !hit;

    // Bus steering
    always_comb begin
        if (state_q == icache_bus_pkg::BYPASS) begin
            // Straight through to memory
            mem_req.access = fetch_req.access;
            mem_req.addr   = fetch_req.addr;
            fetch_rsp.ack  = mem_rsp.ack;
            fetch_rsp.data = mem_rsp.data;
        end else begin
            // Fill words, access drops in the ack cycle
            mem_req.access = (state_q == icache_bus_pkg::FILL) && !mem_rsp.ack;
            mem_req.addr   = fill_fetch_addr;
            fetch_rsp.ack  = ack_q;
            fetch_rsp.data = data_q;
        end
    end

endmodule

//--- rtl/icache_top.sv
// Read-only direct-mapped instruction cache, top level
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       enabled,
    input  icache_bus_pkg::fetch_req_t fetch_req,
    output icache_bus_pkg::fetch_rsp_t fetch_rsp,
    output icache_bus_pkg::mem_req_t   mem_req,
    input  icache_bus_pkg::mem_rsp_t   mem_rsp
);

    // Lookup path
    icache_types_pkg::word_addr_t  lookup_addr;
    logic                          hit;
    icache_types_pkg::data_word_t  rd_data;

    // Fill path
    logic                          fill_start;
    icache_types_pkg::word_addr_t  fill_addr;
    icache_types_pkg::word_addr_t  fill_fetch_addr;
    icache_types_pkg::store_addr_t fill_store_addr;
    logic                          line_done;

    // Memory acks count as fill words only in cache mode
    logic                          fill_ack;

    assign fill_ack = mem_rsp.ack & enabled;

    icache_ctrl u_ctrl (
        .clk             (clk),
        .reset           (reset),
        .enabled         (enabled),
        .fetch_req       (fetch_req),
        .fetch_rsp       (fetch_rsp),
        .mem_req         (mem_req),
        .mem_rsp         (mem_rsp),
        .lookup_addr     (lookup_addr),
        .hit             (hit),
        .rd_data         (rd_data),
        .fill_start      (fill_start),
        .fill_addr       (fill_addr),
        .fill_fetch_addr (fill_fetch_addr),
        .line_done       (line_done)
    );

    icache_tag_store u_tags (
        .clk         (clk),
        .reset       (reset),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .fill_start  (fill_start),
        .fill_addr   (fill_addr),
        .line_done   (line_done)
    );

    // Index and offset of the lookup address select the word
    icache_data_store u_data (
        .clk     (clk),
        .rd_addr (lookup_addr[`ICACHE_INDEX_W+`ICACHE_OFFSET_W-1:0]),
        .rd_data (rd_data),
        .wr_en   (fill_ack),
        .wr_addr (fill_store_addr),
        .wr_data (mem_rsp.data)
    );

    icache_fill_unit u_fill (
        .clk        (clk),
        .reset      (reset),
        .fill_start (fill_start),
        .fill_addr  (fill_addr),
        .word_ack   (fill_ack),
        .fetch_addr (fill_fetch_addr),
        .store_addr (fill_store_addr),
        .line_done  (line_done)
    );

endmodule

//--- verification/icache_properties.sv
// Concurrent checks on the fetch and memory handshakes of the instruction cache
`timescale 1ns/10ps

module icache_properties (
    input logic                       clk,
    input logic                       reset,
    input icache_bus_pkg::fetch_req_t fetch_req,
    input icache_bus_pkg::fetch_rsp_t fetch_rsp,
    input icache_bus_pkg::mem_req_t   mem_req,
    input icache_bus_pkg::mem_rsp_t   mem_rsp,
    input logic                       fill_start,
    input logic                       line_done
);

    // Ack only answers a fetch that is still held
    fetch_ack_needs_access: assert property (
        @(posedge clk) disable iff (reset)
        fetch_rsp.ack |-> fetch_req.access
    ) else $error("fetch ack seen while fetch access is low");

    // Single-cycle ack
    fetch_ack_one_cycle: assert property (
        @(posedge clk) disable iff (reset)
        fetch_rsp.ack |=> !fetch_rsp.ack
    ) else $error("fetch ack held for more than one cycle");

    // Waiting request keeps its address until the memory answers
    // Access drops in the ack cycle, so ack also ends the hold
    mem_addr_stable: assert property (
        @(posedge clk) disable iff (reset)
        (mem_req.access && !mem_rsp.ack) |=>
            ($stable(mem_req.addr) && (mem_req.access || mem_rsp.ack))
    ) else $error("memory address changed or access dropped before ack");

    // Fill cannot start and finish in one cycle
    fill_start_not_with_done: assert property (
        @(posedge clk) disable iff (reset)
        !(fill_start && line_done)
    ) else $error("fill_start and line_done high in the same cycle");

endmodule

//--- verification/icache_tb.sv
// Directed testbench for the instruction cache, with a delayed-ack memory model
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_tb;

    localparam int FETCH_TIMEOUT = 200;
    localparam int LINE_WORDS    = `ICACHE_LINE_WORDS;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       enabled;
    icache_bus_pkg::fetch_req_t fetch_req;
    icache_bus_pkg::fetch_rsp_t fetch_rsp;
    icache_bus_pkg::mem_req_t   mem_req;
    icache_bus_pkg::mem_rsp_t   mem_rsp;

    // Addresses of the memory transactions, oldest first
    icache_types_pkg::word_addr_t mem_log [$];

    // Direct-mapped prediction of the resident lines
    icache_types_pkg::line_tag_t  pred_tag [`ICACHE_LINES];
    bit                           pred_valid [`ICACHE_LINES];

    icache_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .enabled   (enabled),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    bind icache_top icache_properties u_props (
        .clk        (clk),
        .reset      (reset),
        .fetch_req  (fetch_req),
        .fetch_rsp  (fetch_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .fill_start (fill_start),
        .line_done  (line_done)
    );

    always #5 clk = ~clk;

    // Memory contents, low address bits scrambled by a constant
    function automatic icache_types_pkg::data_word_t mem_word(
        input icache_types_pkg::word_addr_t addr
    );
        return addr[15:0] ^ 16'h5a3c;
    endfunction

    // Word address as tag | index | offset
    function automatic icache_types_pkg::word_addr_t make_addr(
        input icache_types_pkg::line_tag_t    tag,
        input icache_types_pkg::line_index_t  index,
        input icache_types_pkg::word_offset_t offset
    );
        return {tag, index, offset};
    endfunction

    // Memory model
    // Answers on the falling edge after 0 to 3 cycles, ack lasts one cycle
    initial begin : memory_model
        int wait_left;
        bit busy;
        mem_rsp   = '0;
        wait_left = 0;
        busy      = 1'b0;
        forever begin
            @(negedge clk);
            if (mem_rsp.ack) begin
                mem_rsp = '0;
            end else if (mem_req.access) begin
                if (!busy) begin
                    busy      = 1'b1;
                    wait_left = int'($urandom_range(3, 0));
                end
                if (wait_left == 0) begin
                    mem_log.push_back(mem_req.addr);
                    mem_rsp.ack  = 1'b1;
                    mem_rsp.data = mem_word(mem_req.addr);
                    busy         = 1'b0;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_on_failure($sformatf("error: %s is 0x%0h, expected 0x%0h",
                                      what, actual, expected));
        end
    endtask

    // Reset for two cycles, outputs must be quiet right after
    task automatic apply_reset();
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(posedge clk);
        check_value("fetch_rsp.ack", 32'(fetch_rsp.ack), 32'd0);
        check_value("mem_req.access", 32'(mem_req.access), 32'd0);
    endtask

    // One fetch, access held until ack is sampled on a rising edge
    // Latency counts edges from the request edge to the edge that raises ack
    task automatic fetch_word(input icache_types_pkg::word_addr_t addr,
                              output icache_types_pkg::data_word_t data,
                              output int latency);
        int waited;
        bit got;
        waited = 0;
        got    = 1'b0;
        data   = '0;
        @(negedge clk);
        fetch_req.access = 1'b1;
        fetch_req.addr   = addr;
        while (!got && waited < FETCH_TIMEOUT) begin
            @(posedge clk);
            waited++;
            if (fetch_rsp.ack) begin
                got  = 1'b1;
                data = fetch_rsp.data;
            end
        end
        if (!got) begin
            stop_on_failure($sformatf("no fetch ack within %0d cycles for address 0x%0h",
                                      FETCH_TIMEOUT, addr));
        end
        @(negedge clk);
        fetch_req.access = 1'b0;
        // Ack sampled one edge after it rose, request sampled on the first edge
        latency = waited - 2;
    endtask

    task automatic fetch_and_check(input icache_types_pkg::word_addr_t addr,
                                   output int latency);
        icache_types_pkg::data_word_t data;
        fetch_word(addr, data, latency);
        check_value("fetch_rsp.data", 32'(data), 32'(mem_word(addr)));
    endtask

    // Whole line fetched, starting at the requested word and wrapping
    task automatic check_line_fill(input icache_types_pkg::word_addr_t addr);
        icache_types_pkg::word_offset_t offset;
        check_value("memory request count", 32'(mem_log.size()), 32'(LINE_WORDS));
        for (int i = 0; i < LINE_WORDS; i++) begin
            offset = addr[`ICACHE_OFFSET_W-1:0] + icache_types_pkg::word_offset_t'(i);
            check_value("mem_req.addr", 32'(mem_log[i]),
                        32'({addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], offset}));
        end
    endtask

    task automatic test_cold_miss();
        int latency;
        mem_log.delete();
        fetch_and_check(make_addr(8'h12, 8'h40, 3'd5), latency);
        check_line_fill(make_addr(8'h12, 8'h40, 3'd5));
    endtask

    // Other words of the same line, no memory traffic and fixed latency
    task automatic test_hit();
        int latency;
        icache_types_pkg::word_offset_t offsets [3];
        offsets = '{3'd0, 3'd7, 3'd5};
        foreach (offsets[i]) begin
            mem_log.delete();
            fetch_and_check(make_addr(8'h12, 8'h40, offsets[i]), latency);
            check_value("memory request count", 32'(mem_log.size()), 32'd0);
            check_value("hit latency", 32'(latency), 32'd3);
        end
    endtask

    // Same index, other tag, then back to the first line
    task automatic test_conflict();
        int latency;
        mem_log.delete();
        fetch_and_check(make_addr(8'h34, 8'h40, 3'd2), latency);
        check_line_fill(make_addr(8'h34, 8'h40, 3'd2));
        mem_log.delete();
        fetch_and_check(make_addr(8'h12, 8'h40, 3'd6), latency);
        check_line_fill(make_addr(8'h12, 8'h40, 3'd6));
    endtask

    // Disabled cache, one memory transaction per fetch at the fetch address
    task automatic test_bypass();
        int latency;
        icache_types_pkg::word_addr_t addrs [3];
        addrs = '{19'h2_4401, 19'h7_ffff, 19'h0_0003};
        enabled = 1'b0;
        foreach (addrs[i]) begin
            mem_log.delete();
            fetch_and_check(addrs[i], latency);
            check_value("memory request count", 32'(mem_log.size()), 32'd1);
            check_value("mem_req.addr", 32'(mem_log[0]), 32'(addrs[i]));
        end
        enabled = 1'b1;
        // Line filled before the bypass still hits with its own data
        mem_log.delete();
        fetch_and_check(make_addr(8'h12, 8'h40, 3'd6), latency);
        check_value("memory request count", 32'(mem_log.size()), 32'd0);
    endtask

    // Reset empties the cache, then a random walk over four lines
    task automatic test_reset_and_mixed();
        int latency;
        int line_changes;
        int sel;
        icache_types_pkg::line_tag_t    tags [4];
        icache_types_pkg::line_index_t  indexes [4];
        icache_types_pkg::word_offset_t offset;
        tags    = '{8'h12, 8'h34, 8'h12, 8'h56};
        indexes = '{8'h40, 8'h40, 8'h41, 8'h7f};
        apply_reset();
        mem_log.delete();
        fetch_and_check(make_addr(8'h12, 8'h40, 3'd1), latency);
        check_line_fill(make_addr(8'h12, 8'h40, 3'd1));
        // Only the line just fetched is resident
        foreach (pred_valid[i]) begin
            pred_valid[i] = 1'b0;
        end
        pred_valid[8'h40] = 1'b1;
        pred_tag[8'h40]   = 8'h12;
        line_changes = 0;
        mem_log.delete();
        for (int n = 0; n < 40; n++) begin
            sel    = int'($urandom_range(3, 0));
            offset = icache_types_pkg::word_offset_t'($urandom_range(7, 0));
            if (!pred_valid[indexes[sel]] || pred_tag[indexes[sel]] != tags[sel]) begin
                line_changes++;
                pred_valid[indexes[sel]] = 1'b1;
                pred_tag[indexes[sel]]   = tags[sel];
            end
            fetch_and_check(make_addr(tags[sel], indexes[sel], offset), latency);
        end
        check_value("memory request count", 32'(mem_log.size()),
                    32'(line_changes * LINE_WORDS));
    endtask

    initial begin
        void'($urandom(32'he4a7c966));
        enabled   = 1'b1;
        fetch_req = '0;
        apply_reset();
        test_cold_miss();
        test_hit();
        test_conflict();
        test_bypass();
        test_reset_and_mixed();
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- project.f
+incdir+rtl
rtl/icache_types_pkg.sv
rtl/icache_bus_pkg.sv
rtl/icache_tag_store.sv
rtl/icache_data_store.sv
rtl/icache_fill_unit.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
verification/icache_properties.sv
verification/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the instruction cache testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 \
    --top-module icache_tb -Mdir obj_dir -f project.f \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/Vicache_tb > sim.log 2>&1
cat sim.log

grep -q "All tests passed!" sim.log \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }
